// ==== verilog/riscv_isa_pkg.sv ====
`default_nettype none

package riscv_isa_pkg;

  // major opcodes, bits [6:0] of a 32-bit instruction
  typedef enum logic [6:0] {
    LOAD   = 7'b000_0011,
    STORE  = 7'b010_0011,
    OP_IMM = 7'b001_0011,
    OP     = 7'b011_0011,
    LUI    = 7'b011_0111,
    AUIPC  = 7'b001_0111,
    JAL    = 7'b110_1111,
    JALR   = 7'b110_0111,
    BRANCH = 7'b110_0011,
    SYSTEM = 7'b111_0011
  } opcode_e;

  // predecode result, what the fetch side needs to know
  // about control flow before decode
  typedef enum logic [1:0] {
    CLASS_SEQ    = 2'd0, // falls through to pc + 4
    CLASS_BRANCH = 2'd1, // conditional
    CLASS_JUMP   = 2'd2, // jal / jalr
    CLASS_SYSTEM = 2'd3  // ecall, ebreak, csr ops
  } inst_class_e;

endpackage : riscv_isa_pkg

`default_nettype wire

// ==== verilog/frontend_pkg.sv ====
`default_nettype none

package frontend_pkg;

  // redirect from a later stage
  // same shape for trap (mem) and branch (exe)
  typedef struct packed {
    logic        valid;
    logic [31:0] target;
  } redirect_t;

  // resolved taken branch that trains the btb
  typedef struct packed {
    logic        valid;
    logic [31:0] pc;     // pc of the branch itself
    logic [31:0] target; // where it went
  } bp_update_t;

  // one fetched instruction on its way to decode
  typedef struct packed {
    logic [31:0]               pc;
    logic [31:0]               inst;
    logic                      pred_taken; // btb hit at this pc
    riscv_isa_pkg::inst_class_e inst_class;
  } fetch_pkt_t;

endpackage : frontend_pkg

`default_nettype wire

// ==== verilog/pc_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module pc_gen #(
  parameter int unsigned       XLEN       = 32,
  parameter logic [XLEN-1:0]   RESET_ADDR = 32'h8000_0000
) (
  input  wire logic                    clk,
  input  wire logic                    reset_i,
  input  wire logic                    stall_i,
  input  wire logic                    flush_i,
  input  wire frontend_pkg::redirect_t trap_i,   // from mem
  input  wire frontend_pkg::redirect_t branch_i, // from exe
  input  wire logic                    bp_hit_i,
  input  wire logic [XLEN-1:0]         bp_target_i,
  output logic      [XLEN-1:0]         fetch_addr_o,
  output logic      [XLEN-1:0]         pc_o,
  output logic                         read_req_o
);

  logic [XLEN-1:0] pc_q;
  logic            boot_q;      // first cycle out of reset
  logic [XLEN-1:0] pc_plus4;
  logic [XLEN-1:0] next_pc;
  logic [XLEN-1:0] next_pc_d;

  assign pc_plus4 = pc_q + XLEN'(4);

  // fixed priority, trap beats branch beats prediction
  always_comb begin
    if (trap_i.valid) begin
      next_pc = trap_i.target;
    end else if (branch_i.valid) begin
      next_pc = branch_i.target;
    end else if (bp_hit_i) begin
      next_pc = bp_target_i; // btb entry for pc_q
    end else begin
      next_pc = pc_plus4;
    end
  end

  assign next_pc_d = flush_i ? RESET_ADDR : next_pc;

  // held pc is re-fetched while stalled and in the boot cycle
  assign fetch_addr_o = (stall_i || boot_q) ? pc_q : next_pc_d;

  // pc follows the fetch address, so pc_o always names
  // the word the cache is returning this cycle
  always_ff @(posedge clk) begin
    if (reset_i) begin
      pc_q   <= RESET_ADDR;
      boot_q <= 1'b1;
    end else begin
      pc_q   <= fetch_addr_o;
      boot_q <= 1'b0;
    end
  end

  assign pc_o       = pc_q;
  assign read_req_o = ~reset_i; // fetch every cycle once out of reset

endmodule : pc_gen

`default_nettype wire

// ==== verilog/btb.sv ====
`timescale 1ns/1ps
`default_nettype none

module btb #(
  parameter int unsigned XLEN        = 32,
  parameter int unsigned BTB_ENTRIES = 16
) (
  input  wire logic                     clk,
  input  wire logic                     reset_i,
  input  wire logic [XLEN-1:0]          lookup_addr_i,
  input  wire frontend_pkg::bp_update_t update_i,
  output logic                          hit_o,
  output logic      [XLEN-1:0]          target_o
);

  localparam int unsigned IDX_W = $clog2(BTB_ENTRIES);
  localparam int unsigned TAG_W = XLEN - IDX_W - 2;

  logic [BTB_ENTRIES-1:0] valid_q;
  logic [TAG_W-1:0]       tag_mem    [BTB_ENTRIES];
  logic [XLEN-1:0]        target_mem [BTB_ENTRIES];

  logic [IDX_W-1:0] rd_idx;
  logic [TAG_W-1:0] rd_tag;
  logic [IDX_W-1:0] wr_idx;
  logic [TAG_W-1:0] wr_tag;

  logic             hit_q;
  logic [XLEN-1:0]  target_q;

  // word address bits index the table and the upper bits are the tag
  assign rd_idx = lookup_addr_i[IDX_W+1:2];
  assign rd_tag = lookup_addr_i[XLEN-1:IDX_W+2];
  assign wr_idx = update_i.pc[IDX_W+1:2];
  assign wr_tag = update_i.pc[XLEN-1:IDX_W+2];

  // per-entry valid bits
  always_ff @(posedge clk) begin
    if (reset_i) begin
      valid_q <= '0;
    end else if (update_i.valid) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (update_i.valid) begin
      tag_mem[wr_idx]    <= wr_tag;
      target_mem[wr_idx] <= update_i.target;
    end
  end

  // registered lookup
  // a same-cycle update to this entry is not seen yet
  always_ff @(posedge clk) begin
    if (reset_i) begin
      hit_q <= 1'b0;
    end else begin
      hit_q <= valid_q[rd_idx] && (tag_mem[rd_idx] == rd_tag);
    end
  end

  always_ff @(posedge clk) begin
    target_q <= target_mem[rd_idx];
  end

  assign hit_o    = hit_q;
  assign target_o = target_q;

endmodule : btb

`default_nettype wire

// ==== verilog/if_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module if_stage (
  input  wire logic                    clk,
  input  wire logic                    reset_i,
  input  wire logic                    stall_i,
  input  wire logic                    flush_i,
  input  wire frontend_pkg::redirect_t trap_i,
  input  wire frontend_pkg::redirect_t branch_i,
  input  wire logic [31:0]             pc_i,
  input  wire logic [31:0]             inst_i,
  input  wire logic                    inst_valid_i,
  input  wire logic                    pred_taken_i,
  output frontend_pkg::fetch_pkt_t     pkt_o,
  output logic                         pkt_valid_o
);

  import riscv_isa_pkg::*;

  opcode_e     opcode;
  inst_class_e inst_class;
  logic        kill;
  logic        capture;

  // predecode, only the major opcode matters here
  always_comb begin
    opcode = opcode_e'(inst_i[6:0]);
    case (opcode)
      BRANCH:    inst_class = CLASS_BRANCH;
      JAL, JALR: inst_class = CLASS_JUMP;
      SYSTEM:    inst_class = CLASS_SYSTEM;
      default:   inst_class = CLASS_SEQ; // alu, loads, stores, unknown
    endcase
  end

  // word arriving now belongs to the wrong path on any redirect
  assign kill    = trap_i.valid | branch_i.valid | flush_i;
  assign capture = inst_valid_i & ~kill & ~stall_i;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      pkt_valid_o <= 1'b0;
    end else if (!stall_i) begin
      pkt_valid_o <= inst_valid_i & ~kill;
    end
  end

  // payload holds while stalled or when nothing new comes in
  always_ff @(posedge clk) begin
    if (capture) begin
      pkt_o.pc         <= pc_i;
      pkt_o.inst       <= inst_i;
      pkt_o.pred_taken <= pred_taken_i;
      pkt_o.inst_class <= inst_class;
    end
  end

endmodule : if_stage

`default_nettype wire

// ==== verilog/frontend_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module frontend_top #(
  parameter int unsigned     XLEN        = 32,
  parameter logic [XLEN-1:0] RESET_ADDR  = 32'h8000_0000,
  parameter int unsigned     BTB_ENTRIES = 16
) (
  input  wire logic                     clk,
  input  wire logic                     reset_i,
  // core side
  input  wire frontend_pkg::redirect_t  trap_i,
  input  wire frontend_pkg::redirect_t  branch_i,
  input  wire frontend_pkg::bp_update_t bp_update_i,
  input  wire logic                     stall_i,
  input  wire logic                     flush_i,
  // icache side
  output logic      [XLEN-1:0]          fetch_addr_o,
  output logic                          read_req_o,
  input  wire logic [31:0]              inst_i,
  input  wire logic                     inst_valid_i,
  // to decode
  output frontend_pkg::fetch_pkt_t      pkt_o,
  output logic                          pkt_valid_o
);

  logic [XLEN-1:0] pc_cur;
  logic            bp_hit;    // btb result for pc_cur
  logic [XLEN-1:0] bp_target;

  pc_gen #(
    .XLEN       (XLEN),
    .RESET_ADDR (RESET_ADDR)
  ) i_pc_gen (
    .clk          (clk),
    .reset_i      (reset_i),
    .stall_i      (stall_i),
    .flush_i      (flush_i),
    .trap_i       (trap_i),
    .branch_i     (branch_i),
    .bp_hit_i     (bp_hit),
    .bp_target_i  (bp_target),
    .fetch_addr_o (fetch_addr_o),
    .pc_o         (pc_cur),
    .read_req_o   (read_req_o)
  );

  // looked up with the outgoing fetch address, answers a cycle later
  btb #(
    .XLEN        (XLEN),
    .BTB_ENTRIES (BTB_ENTRIES)
  ) i_btb (
    .clk           (clk),
    .reset_i       (reset_i),
    .lookup_addr_i (fetch_addr_o),
    .update_i      (bp_update_i),
    .hit_o         (bp_hit),
    .target_o      (bp_target)
  );

  if_stage i_if_stage (
    .clk          (clk),
    .reset_i      (reset_i),
    .stall_i      (stall_i),
    .flush_i      (flush_i),
    .trap_i       (trap_i),
    .branch_i     (branch_i),
    .pc_i         (pc_cur),
    .inst_i       (inst_i),
    .inst_valid_i (inst_valid_i),
    .pred_taken_i (bp_hit),
    .pkt_o        (pkt_o),
    .pkt_valid_o  (pkt_valid_o)
  );

endmodule : frontend_top

`default_nettype wire

// ==== verif/tb_frontend.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_frontend;

  import riscv_isa_pkg::*;
  import frontend_pkg::*;

  localparam logic [31:0] RESET_ADDR  = 32'h8000_0000;
  localparam int unsigned BTB_ENTRIES = 16;
  localparam int unsigned IDX_W       = $clog2(BTB_ENTRIES);
  localparam int unsigned CLK_PERIOD  = 40;
  localparam int unsigned TEST_CYCLES = 200; // all phases including stalls
  localparam int unsigned MARGIN      = 100;
  // 7'h0f is misc-mem (fence) and lies outside the enum
  localparam logic [6:0] OPC_LIST [11] = '{LOAD, STORE, OP_IMM, OP, LUI, AUIPC,
                                           JAL, JALR, BRANCH, SYSTEM, 7'h0f};

  logic        clk;
  logic        reset_i;
  redirect_t   trap_i;
  redirect_t   branch_i;
  bp_update_t  bp_update_i;
  logic        stall_i;
  logic        flush_i;
  logic [31:0] fetch_addr_o;
  logic        read_req_o;
  logic [31:0] inst_i;
  logic        inst_valid_i;
  fetch_pkt_t  pkt_o;
  logic        pkt_valid_o;

  logic [31:0] lcg_state;
  logic [6:0]  opc_tab [64];
  logic        sh_valid [BTB_ENTRIES]; // shadow btb
  logic [31:0] sh_pc [BTB_ENTRIES];
  logic [31:0] sh_tgt [BTB_ENTRIES];
  logic [31:0] m_pc;                   // expected pc_cur
  logic        m_boot;
  logic        m_ivalid;
  logic        m_hit;                  // expected btb answer for m_pc
  logic [31:0] m_tgt;
  logic        stall_last;
  fetch_pkt_t  prev_pkt;               // pkt_o seen at the previous edge
  logic        prev_valid;
  fetch_pkt_t  exp_q [$];
  logic [31:0] last_pc;
  logic        last_pred;
  int unsigned n_checked;

  frontend_top #(
    .XLEN        (32),
    .RESET_ADDR  (RESET_ADDR),
    .BTB_ENTRIES (BTB_ENTRIES)
  ) i_dut (.*);

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // cache contents where every address bit feeds the word
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [5:0]  idx;
    logic [31:0] h;
    idx = addr[7:2] ^ addr[13:8] ^ addr[19:14] ^ addr[25:20] ^ addr[31:26];
    h   = (addr ^ 32'h3c5a_96e1) * 32'h9e37_79b1;
    return {h[31:7], opc_tab[idx]};
  endfunction

  function automatic inst_class_e ref_class(input logic [31:0] inst);
    case (inst[6:0])
      BRANCH:    return CLASS_BRANCH;
      JAL, JALR: return CLASS_JUMP;
      SYSTEM:    return CLASS_SYSTEM;
      default:   return CLASS_SEQ;
    endcase
  endfunction

  function automatic logic [31:0] ref_next_pc(input logic [31:0] pc, input logic hit,
      input logic [31:0] tgt, input redirect_t trap, input redirect_t br, input logic flush);
    logic [31:0] nxt;
    if (trap.valid) nxt = trap.target;
    else if (br.valid) nxt = br.target;
    else if (hit) nxt = tgt;
    else nxt = pc + 32'd4;
    return flush ? RESET_ADDR : nxt; // flush overrides everything
  endfunction

  task automatic check_eq(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERR %s expected %h actual %h", name, expected, actual);
      $display("TEST RESULT: FAIL");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "%s", why);
  endtask

  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic wait_for_pc(input logic [31:0] addr);
    int unsigned start;
    start = n_checked;
    do begin
      step();
    end while (n_checked == start || last_pc != addr);
  endtask

  task automatic wait_packets(input int unsigned n);
    int unsigned start;
    start = n_checked;
    while (n_checked < start + n) step();
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #((TEST_CYCLES + MARGIN) * CLK_PERIOD);
    abort_run("timeout: packets stopped arriving");
  end

  // icache model answering one cycle after the request
  initial begin
    logic [31:0] addr;
    logic        req;
    inst_i       = '0;
    inst_valid_i = 1'b0;
    forever begin
      @(posedge clk);
      addr = fetch_addr_o;
      req  = read_req_o;
      #2;
      inst_valid_i = req;
      inst_i       = req ? mem_word(addr) : 32'h0;
    end
  end

  // comparator runs first and the model then steps on the same pre-edge values
  always @(posedge clk) begin
    fetch_pkt_t       due;
    logic [31:0]      f;
    logic [31:0]      word;
    logic [IDX_W-1:0] idx;
    logic [IDX_W-1:0] uidx;
    if (stall_last) begin // a stall holds the registered packet
      check_eq("held pkt_valid", 32'(prev_valid), 32'(pkt_valid_o));
      check_eq("held pkt pc", prev_pkt.pc, pkt_o.pc);
      check_eq("held pkt inst", prev_pkt.inst, pkt_o.inst);
    end
    if (pkt_valid_o && !stall_last) begin
      if (exp_q.size() == 0) begin
        abort_run("packet arrived when none was due");
      end else begin
        due = exp_q.pop_front();
        check_eq("pkt pc", due.pc, pkt_o.pc);
        check_eq("pkt inst", due.inst, pkt_o.inst);
        check_eq("pkt inst_class", 32'(due.inst_class), 32'(pkt_o.inst_class));
        check_eq("pkt pred_taken", 32'(due.pred_taken), 32'(pkt_o.pred_taken));
        last_pc   = pkt_o.pc;
        last_pred = pkt_o.pred_taken;
        n_checked = n_checked + 1;
      end
    end else if (exp_q.size() != 0) begin
      abort_run("expected packet did not arrive");
    end
    if (reset_i) begin
      check_eq("read_req in reset", 32'd0, 32'(read_req_o));
      m_pc     = RESET_ADDR;
      m_boot   = 1'b1;
      m_ivalid = 1'b0;
      m_hit    = 1'b0;
      exp_q.delete();
    end else begin
      word = mem_word(m_pc);
      if (m_ivalid && !trap_i.valid && !branch_i.valid && !flush_i && !stall_i) begin
        due.pc         = m_pc;
        due.inst       = word;
        due.pred_taken = m_hit;
        due.inst_class = ref_class(word);
        exp_q.push_back(due);
      end
      f = (stall_i || m_boot) ? m_pc
                              : ref_next_pc(m_pc, m_hit, m_tgt, trap_i, branch_i, flush_i);
      check_eq("fetch_addr", f, fetch_addr_o);
      check_eq("read_req", 32'd1, 32'(read_req_o));
      idx   = f[IDX_W+1:2];
      m_hit = sh_valid[idx] && (sh_pc[idx][31:2] == f[31:2]); // old contents
      m_tgt = sh_tgt[idx];
      if (bp_update_i.valid) begin
        uidx           = bp_update_i.pc[IDX_W+1:2];
        sh_valid[uidx] = 1'b1;
        sh_pc[uidx]    = bp_update_i.pc;
        sh_tgt[uidx]   = bp_update_i.target;
      end
      m_pc     = f;
      m_boot   = 1'b0;
      m_ivalid = 1'b1;
    end
    prev_pkt   = pkt_o;
    prev_valid = pkt_valid_o;
    stall_last = stall_i;
  end

  initial begin
    logic [3:0] pick;
    lcg_state = 32'he682;
    for (int i = 0; i < 64; i++) begin
      lcg_state  = lcg_next(lcg_state);
      pick       = 4'(lcg_state[31:16] % 16'd11);
      opc_tab[i] = OPC_LIST[pick];
    end
    for (int i = 0; i < BTB_ENTRIES; i++) sh_valid[i] = 1'b0;
    reset_i     = 1'b1;
    trap_i      = '0;
    branch_i    = '0;
    bp_update_i = '0;
    stall_i     = 1'b0;
    flush_i     = 1'b0;
    stall_last  = 1'b0;
    last_pc     = '0;
    last_pred   = 1'b0;
    n_checked   = 0;
    repeat (4) @(posedge clk);
    #2;
    reset_i = 1'b0;
    wait_for_pc(RESET_ADDR + 32'h40); // boot and straight-line fetch
    // taken branch that the btb learns for pc 0x20
    branch_i    = '{valid: 1'b1, target: 32'h8000_0400};
    bp_update_i = '{valid: 1'b1, pc: RESET_ADDR + 32'h20, target: 32'h8000_0400};
    step();
    branch_i    = '0;
    bp_update_i = '0;
    wait_for_pc(32'h8000_0410);
    flush_i = 1'b1;
    step();
    flush_i = 1'b0;
    wait_for_pc(RESET_ADDR);
    wait_for_pc(RESET_ADDR + 32'h20);
    check_eq("btb pred_taken", 32'd1, 32'(last_pred));
    wait_packets(1);
    check_eq("pc after prediction", 32'h8000_0400, last_pc);
    // trap and branch together
    trap_i   = '{valid: 1'b1, target: 32'h8000_0800};
    branch_i = '{valid: 1'b1, target: 32'h8000_0c00};
    step();
    trap_i   = '0;
    branch_i = '0;
    wait_packets(1);
    check_eq("pc after trap", 32'h8000_0800, last_pc);
    repeat (60) begin
      lcg_state = lcg_next(lcg_state);
      stall_i   = lcg_state[28];
      step();
    end
    stall_i = 1'b0;
    wait_packets(72); // long straight run for predecode
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule : tb_frontend

`default_nettype wire

// ==== sources.f ====
verilog/riscv_isa_pkg.sv
verilog/frontend_pkg.sv
verilog/pc_gen.sv
verilog/btb.sv
verilog/if_stage.sv
verilog/frontend_top.sv
verif/tb_frontend.sv

// ==== Makefile ====
TOP := tb_frontend

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): sources.f verilog/*.sv verif/*.sv
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f sources.f

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f sources.f

clean:
	rm -rf obj_dir
